// File: logic/spi_ram_pkg.sv
package spi_ram_pkg;

  // command byte, first byte of every frame
  typedef enum logic [7:0] {
    op_write = 8'h00,
    op_read  = 8'h01
  } spi_op_e;

  // slave frame phases
  typedef enum logic [2:0] {
    st_cmd,    // waiting for the command byte
    st_addr,   // collecting address bytes, msb first
    st_dummy,  // read frames only, gives the store time
    st_data,   // byte stream with auto increment
    st_idle    // bad command, ignore until csn rises
  } slave_state_e;

  // top address byte selects the target
  localparam logic [7:0] region_ram  = 8'h00;
  localparam logic [7:0] region_ctrl = 8'hFF;

  // word store data width
  localparam int word_bits = 16;

endpackage

// File: logic/word_store.sv
module word_store #(
  parameter int store_addr_bits = 10
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              req,
  input  logic                              we,
  input  logic [store_addr_bits-1:0]        word_addr,
  input  logic [spi_ram_pkg::word_bits-1:0] wdata,
  output logic [spi_ram_pkg::word_bits-1:0] rdata
);

  logic [spi_ram_pkg::word_bits-1:0] mem [2**store_addr_bits];

  logic [2:0]                        pace;  // free running divide by 8
  logic                              tick;
  logic                              pend;
  logic                              pend_we;
  logic [store_addr_bits-1:0]        pend_addr;
  logic [spi_ram_pkg::word_bits-1:0] pend_data;

  assign tick = pace == 3'd7;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pace  <= '0;
      pend  <= 1'b0;
      rdata <= '0;
    end
    else
    begin
      pace <= pace + 3'd1;
      if (req)
        pend <= 1'b1;
      else if (tick)
        pend <= 1'b0;
      if (tick && pend && !pend_we)
        rdata <= mem[pend_addr];
    end
  end

  // a newer request overwrites the pending one
  always_ff @(posedge clk)
  begin
    if (req)
    begin
      pend_we   <= we;
      pend_addr <= word_addr;
      pend_data <= wdata;
    end
  end

  always_ff @(posedge clk)
  begin
    if (tick && pend && pend_we)
      mem[pend_addr] <= pend_data;
  end

  a_we_with_req: assert property (@(posedge clk) disable iff (!rst_n) we |-> req);

endmodule

// File: logic/byte_word_bridge.sv
module byte_word_bridge #(
  parameter int addr_bits       = 32,
  parameter int store_addr_bits = 10
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              rd,
  input  logic                              wr,
  input  logic [addr_bits-1:0]              addr,
  input  logic [7:0]                        wr_data,
  input  logic [spi_ram_pkg::word_bits-1:0] rdata,
  output logic [7:0]                        rd_data,
  output logic                              req,
  output logic                              we,
  output logic [store_addr_bits-1:0]        word_addr,
  output logic [spi_ram_pkg::word_bits-1:0] wdata,
  output logic [7:0]                        control
);

  logic [7:0] region;
  logic       in_ram;
  logic       in_ctrl;
  logic       word_wr;
  logic       word_rd;
  logic [7:0] even_byte;  // high half of the next word
  logic [7:0] odd_byte;   // low half

  assign region  = addr[addr_bits-1 -: 8];
  assign in_ram  = region == spi_ram_pkg::region_ram;
  assign in_ctrl = region == spi_ram_pkg::region_ctrl;

  // the odd byte completes a word
  assign word_wr = wr && in_ram && addr[0];
  assign word_rd = rd && in_ram;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      req     <= 1'b0;
      we      <= 1'b0;
      control <= '0;
    end
    else
    begin
      req <= word_wr || word_rd;
      we  <= word_wr;
      if (wr && in_ctrl)
        control <= wr_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr && in_ram)
    begin
      if (addr[0])
        odd_byte <= wr_data;
      else
        even_byte <= wr_data;
    end
    if (word_wr || word_rd)
      word_addr <= addr[store_addr_bits:1];  // upper bits alias
  end

  assign wdata = {even_byte, odd_byte};

  // byte select on the returned word
  always_comb
  begin
    if (in_ram)
      rd_data = addr[0] ? rdata[7:0] : rdata[spi_ram_pkg::word_bits-1 -: 8];
    else if (in_ctrl)
      rd_data = control;
    else
      rd_data = 8'h00;  // unmapped
  end

  a_req_single: assert property (@(posedge clk) disable iff (!rst_n) req |=> !req);

endmodule

// File: logic/spi_rw_slave.sv
module spi_rw_slave #(
  parameter int addr_bits = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 csn,
  input  logic                 sclk,
  input  logic                 mosi,
  input  logic [7:0]           rd_data,
  output logic                 miso,
  output logic                 rd,
  output logic                 wr,
  output logic [addr_bits-1:0] addr,
  output logic [7:0]           wr_data
);

  localparam int addr_bytes = addr_bits / 8;

  spi_ram_pkg::slave_state_e state;
  spi_ram_pkg::spi_op_e      op;

  logic [1:0] csn_q;
  logic [2:0] sclk_q;     // two sync stages plus edge detect
  logic [1:0] mosi_q;
  logic       csn_s;
  logic       sclk_rise;
  logic       sclk_fall;
  logic [2:0] bit_cnt;
  logic [2:0] byte_cnt;
  logic [7:0] shift_in;
  logic [7:0] shift_out;
  logic       byte_done;  // shift_in holds a complete byte
  logic       load_pend;  // next falling edge loads rd_data
  logic       first;      // first write byte goes to the address as sent
  logic       rd_go;
  logic       wr_go;
  logic       data_load;
  logic       addr_inc;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      csn_q  <= 2'b11;
      sclk_q <= '0;
      mosi_q <= '0;
    end
    else
    begin
      csn_q  <= {csn_q[0], csn};
      sclk_q <= {sclk_q[1:0], sclk};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  assign csn_s     = csn_q[1];
  assign sclk_rise = sclk_q[1] & ~sclk_q[2];
  assign sclk_fall = ~sclk_q[1] & sclk_q[2];
  assign data_load = sclk_fall & load_pend & ~csn_s;

  // reads step after each load, writes step on every byte but the first
  assign addr_inc = ~csn_s && state == spi_ram_pkg::st_data &&
                    ((data_load && op == spi_ram_pkg::op_read) ||
                     (byte_done && op == spi_ram_pkg::op_write && !first));

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state     <= spi_ram_pkg::st_cmd;
      op        <= spi_ram_pkg::op_write;
      bit_cnt   <= '0;
      byte_cnt  <= '0;
      byte_done <= 1'b0;
      load_pend <= 1'b0;
      first     <= 1'b0;
      rd_go     <= 1'b0;
      wr_go     <= 1'b0;
      rd        <= 1'b0;
      wr        <= 1'b0;
      shift_out <= '0;
    end
    else if (csn_s)
    begin
      // frame end, also aborts mid frame
      state     <= spi_ram_pkg::st_cmd;
      bit_cnt   <= '0;
      byte_cnt  <= '0;
      byte_done <= 1'b0;
      load_pend <= 1'b0;
      rd_go     <= 1'b0;
      wr_go     <= 1'b0;
      rd        <= 1'b0;
      wr        <= 1'b0;
      shift_out <= '0;
    end
    else
    begin
      rd        <= rd_go;
      wr        <= wr_go;
      rd_go     <= 1'b0;
      wr_go     <= 1'b0;
      byte_done <= sclk_rise && bit_cnt == 3'd7;
      if (sclk_rise)
        bit_cnt <= bit_cnt + 3'd1;
      if (sclk_fall)
        shift_out <= load_pend ? rd_data : {shift_out[6:0], 1'b0};
      if (data_load)
      begin
        load_pend <= 1'b0;
        if (state == spi_ram_pkg::st_data)
          rd_go <= 1'b1;  // prefetch the byte after this one
      end
      if (byte_done)
      begin
        case (state)
          spi_ram_pkg::st_cmd:
            if (shift_in == spi_ram_pkg::op_write || shift_in == spi_ram_pkg::op_read)
            begin
              op    <= spi_ram_pkg::spi_op_e'(shift_in);
              state <= spi_ram_pkg::st_addr;
            end
            else
              state <= spi_ram_pkg::st_idle;
          spi_ram_pkg::st_addr:
          begin
            byte_cnt <= byte_cnt + 3'd1;
            if (byte_cnt == 3'(addr_bytes - 1))
            begin
              if (op == spi_ram_pkg::op_read)
              begin
                state     <= spi_ram_pkg::st_dummy;
                rd_go     <= 1'b1;  // first read request, a byte ahead
                load_pend <= 1'b1;
              end
              else
              begin
                state <= spi_ram_pkg::st_data;
                first <= 1'b1;
              end
            end
          end
          spi_ram_pkg::st_dummy:
          begin
            state     <= spi_ram_pkg::st_data;
            load_pend <= 1'b1;
          end
          spi_ram_pkg::st_data:
            if (op == spi_ram_pkg::op_read)
              load_pend <= 1'b1;
            else
            begin
              wr_go <= 1'b1;
              first <= 1'b0;
            end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      shift_in <= {shift_in[6:0], mosi_q[1]};
    if (byte_done && state == spi_ram_pkg::st_addr && !csn_s)
      addr <= {addr[addr_bits-9:0], shift_in};  // msb byte first
    else if (addr_inc)
      addr <= addr + 1'b1;
    if (byte_done && state == spi_ram_pkg::st_data)
      wr_data <= shift_in;
  end

  assign miso = shift_out[7];

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(rd && wr));
  a_no_strobe_idle: assert property (@(posedge clk) disable iff (!rst_n)
    csn_s |-> !(rd || wr));

endmodule

// File: logic/spi_ram_top.sv
module spi_ram_top (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       csn,
  input  logic       sclk,
  input  logic       mosi,
  output logic       miso,
  output logic [7:0] control
);

  localparam int addr_bits       = 32;
  localparam int store_addr_bits = 10;  // 1k words kept

  // slave to bridge
  wire                              rd;
  wire                              wr;
  wire [addr_bits-1:0]              addr;
  wire [7:0]                        wr_data;
  wire [7:0]                        rd_data;

  // bridge to store
  wire                              req;
  wire                              we;
  wire [store_addr_bits-1:0]        word_addr;
  wire [spi_ram_pkg::word_bits-1:0] wdata;
  wire [spi_ram_pkg::word_bits-1:0] rdata;

  spi_rw_slave #(
    .addr_bits(addr_bits)
  ) u_slave (
    .clk     (clk),
    .rst_n   (rst_n),
    .csn     (csn),
    .sclk    (sclk),
    .mosi    (mosi),
    .rd_data (rd_data),
    .miso    (miso),
    .rd      (rd),
    .wr      (wr),
    .addr    (addr),
    .wr_data (wr_data)
  );

  byte_word_bridge #(
    .addr_bits      (addr_bits),
    .store_addr_bits(store_addr_bits)
  ) u_bridge (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd       (rd),
    .wr       (wr),
    .addr     (addr),
    .wr_data  (wr_data),
    .rdata    (rdata),
    .rd_data  (rd_data),
    .req      (req),
    .we       (we),
    .word_addr(word_addr),
    .wdata    (wdata),
    .control  (control)
  );

  word_store #(
    .store_addr_bits(store_addr_bits)
  ) u_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .we       (we),
    .word_addr(word_addr),
    .wdata    (wdata),
    .rdata    (rdata)
  );

endmodule

// File: dv/spi_ram_tb.sv
module spi_ram_tb;

  localparam int n_rows   = 13;
  localparam int half_clk = 8;  // sclk half period in clk cycles
  localparam logic [7:0] op_wr = 8'h00;
  localparam logic [7:0] op_rd = 8'h01;

  logic       clk;
  logic       rst_n;
  logic       csn;
  logic       sclk;
  logic       mosi;
  logic       miso;
  logic [7:0] control;

  // transaction table
  string       row_name  [n_rows];
  logic [7:0]  row_op    [n_rows];
  logic [31:0] row_addr  [n_rows];
  int          row_count [n_rows];
  int          row_cut   [n_rows];  // address bytes sent before the frame ends
  logic [7:0]  row_data  [n_rows][8];

  // reference model of the byte space
  logic [7:0] ref_mem   [2048];
  bit         ref_valid [2048];
  logic [7:0] even_latch;
  bit         even_known;
  logic [7:0] ctrl_ref;

  integer seed;
  int     errors;
  int     checks;
  bit     aborted;
  int     i;

  spi_ram_top dut0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .csn    (csn),
    .sclk   (sclk),
    .mosi   (mosi),
    .miso   (miso),
    .control(control)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // inputs change just after the rising edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("FAILED %s expected %02h actual %02h", name, exp, act);
      errors++;
    end
  endtask

  task automatic add_row(input int r, input string name, input logic [7:0] op,
                         input logic [31:0] addr, input int count, input int cut);
    row_name[r]  = name;
    row_op[r]    = op;
    row_addr[r]  = addr;
    row_count[r] = count;
    row_cut[r]   = cut;
    for (int k = 0; k < 8; k++)
      row_data[r][k] = 8'($random(seed));
  endtask

  task automatic build_table;
    add_row(0,  "wr_even8",       op_wr, 32'h0000_0010, 8, 4);
    add_row(1,  "rd_even8",       op_rd, 32'h0000_0010, 8, 4);
    add_row(2,  "wr_next6",       op_wr, 32'h0000_0018, 6, 4);
    add_row(3,  "rd_odd_span",    op_rd, 32'h0000_0013, 8, 4);  // crosses into row 2 data
    add_row(4,  "wr_base4",       op_wr, 32'h0000_0000, 4, 4);
    add_row(5,  "wr_ctrl",        op_wr, 32'hFF00_0000, 1, 4);
    add_row(6,  "rd_ctrl",        op_rd, 32'hFF00_0000, 2, 4);
    add_row(7,  "wr_unmapped",    op_wr, 32'h1200_0000, 4, 4);
    add_row(8,  "rd_unmapped",    op_rd, 32'h1200_0000, 4, 4);
    add_row(9,  "rd_base4",       op_rd, 32'h0000_0000, 4, 4);  // same word index as row 7
    add_row(10, "abort_addr",     op_wr, 32'h0000_0010, 8, 2);
    add_row(11, "bad_cmd",        8'h5A, 32'h0000_0010, 8, 4);
    add_row(12, "rd_after_abort", op_rd, 32'h0000_0010, 8, 4);
  endtask

  task automatic update_ref(input logic [31:0] a, input logic [7:0] d);
    if (a[31:24] == 8'h00)
    begin
      if (!a[0])
      begin
        even_latch = d;
        even_known = 1'b1;
      end
      else
      begin
        // word lands when its odd byte arrives
        ref_mem[{a[10:1], 1'b0}]   = even_latch;
        ref_valid[{a[10:1], 1'b0}] = even_known;
        ref_mem[a[10:0]]           = d;
        ref_valid[a[10:0]]         = 1'b1;
      end
    end
    else if (a[31:24] == 8'hFF)
      ctrl_ref = d;  // any byte of the ctrl region
  endtask

  task automatic expect_byte(input logic [31:0] a, output logic [7:0] exp, output bit known);
    if (a[31:24] == 8'h00)
    begin
      exp   = ref_mem[a[10:0]];
      known = ref_valid[a[10:0]];
    end
    else if (a[31:24] == 8'hFF)
    begin
      exp   = ctrl_ref;
      known = 1'b1;
    end
    else
    begin
      exp   = 8'h00;
      known = 1'b1;
    end
  endtask

  // mode 0 with miso sampled on the rising edge
  task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
    for (int b = 7; b >= 0; b--)
    begin
      mosi = tx[b];
      wait_clks(half_clk);
      sclk  = 1'b1;
      rx[b] = miso;
      wait_clks(half_clk);
      sclk = 1'b0;
    end
  endtask

  task automatic wait_reset_done;
    int n;
    n = 0;
    while ((control !== 8'h00 || miso !== 1'b0) && n < 16)
    begin
      wait_clks(1);
      n++;
    end
    if (control !== 8'h00 || miso !== 1'b0)
    begin
      $display("timeout: DUT outputs never settled after reset was released");
      errors++;
      aborted = 1'b1;
    end
    check_value("reset_control", 8'h00, control);
    check_value("reset_miso", 8'h00, {7'b0, miso});
  endtask

  task automatic wait_frame_end(input string name);
    int n;
    n = 0;
    while ((control !== ctrl_ref || miso !== 1'b0) && n < 8)
    begin
      wait_clks(1);
      n++;
    end
    if (control !== ctrl_ref || miso !== 1'b0)
    begin
      $display("timeout: control or miso did not settle within 8 cycles after csn rose in %s",
               name);
      errors++;
    end
    check_value({name, "_control"}, ctrl_ref, control);
    check_value({name, "_miso_idle"}, 8'h00, {7'b0, miso});
    wait_clks(8);  // csn stays high between frames
  endtask

  task automatic run_frame(input int r);
    logic [7:0]  rx;
    logic [7:0]  exp;
    logic [31:0] a;
    bit          known;
    csn = 1'b0;
    wait_clks(4);
    spi_xfer(row_op[r], rx);
    for (int k = 0; k < row_cut[r]; k++)
      spi_xfer(row_addr[r][31 - 8*k -: 8], rx);
    if (row_cut[r] == 4)
    begin
      if (row_op[r] == op_rd)
      begin
        spi_xfer(8'h00, rx);  // dummy byte
        for (int k = 0; k < row_count[r]; k++)
        begin
          spi_xfer(8'h00, rx);
          a = row_addr[r] + 32'(k);
          expect_byte(a, exp, known);
          if (known)
            check_value(row_name[r], exp, rx);
        end
      end
      else
      begin
        for (int k = 0; k < row_count[r]; k++)
        begin
          spi_xfer(row_data[r][k], rx);
          if (row_op[r] == op_wr)
            update_ref(row_addr[r] + 32'(k), row_data[r][k]);
        end
      end
    end
    wait_clks(half_clk);  // let the last strobe finish
    csn = 1'b1;
    wait_frame_end(row_name[r]);
  endtask

  initial
  begin
    rst_n      = 1'b0;
    csn        = 1'b1;
    sclk       = 1'b0;
    mosi       = 1'b0;
    seed       = 32'hffae;
    errors     = 0;
    checks     = 0;
    aborted    = 1'b0;
    even_latch = 8'h00;
    even_known = 1'b0;
    ctrl_ref   = 8'h00;
    for (int j = 0; j < 2048; j++)
      ref_valid[j] = 1'b0;
    build_table();
    wait_clks(4);
    rst_n = 1'b1;
    wait_reset_done();
    for (i = 0; i < n_rows && !aborted; i++)
      run_frame(i);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: build.f
logic/spi_ram_pkg.sv
logic/word_store.sv
logic/byte_word_bridge.sv
logic/spi_rw_slave.sv
logic/spi_ram_top.sv
dv/spi_ram_tb.sv

// File: Bender.yml
package:
  name: spi_ram

sources:
  - logic/spi_ram_pkg.sv
  - logic/word_store.sv
  - logic/byte_word_bridge.sv
  - logic/spi_rw_slave.sv
  - logic/spi_ram_top.sv
  - target: simulation
    files:
      - dv/spi_ram_tb.sv
